//--- design/d_cache.sv
`timescale 1ns/1ps
`include "nand_cpu_config.svh"

module d_cache
    import nand_cpu_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int INDEX_BITS = 4
) (
    input  logic                                          clk,
    input  logic                                          n_rst,

    input  logic                                          valid,
    input  logic [15:0]                                   address,
    input  mem_op_t                                       mem_op,
    input  logic [15:0]                                   wr_word,
    output logic                                          hit,
    output logic                                          miss,
    output logic [15:0]                                   rd_word,

    output cache_request_t                                mem_req,
    output logic [15 - $clog2(`CACHE_BLOCK_SIZE / 16):0]  mem_addr,
    output logic [`MEM_TRANS_SIZE - 1:0]                  wr_data,
    input  logic                                          mem_ack,
    input  logic [`MEM_TRANS_SIZE - 1:0]                  rd_data
);

    localparam int WORD_BITS   = 16;
    localparam int OFFSET_BITS = $clog2(`CACHE_BLOCK_SIZE / WORD_BITS);
    localparam int TAG_BITS    = 16 - INDEX_BITS - OFFSET_BITS;
    localparam int LINES       = 2 ** INDEX_BITS;
    localparam int BEATS       = `CACHE_BLOCK_SIZE / `MEM_TRANS_SIZE;
    localparam int COUNT_BITS  = (BEATS > 1) ? $clog2(BEATS) : 1;

    logic [OFFSET_BITS - 1:0]      offset;
    logic [INDEX_BITS - 1:0]       index;
    logic [TAG_BITS - 1:0]         tag;

    // line array, valid and dirty are control bits
    logic [LINES - 1:0]            line_valid;
    logic [LINES - 1:0]            line_dirty;
    logic [TAG_BITS - 1:0]         line_tag [LINES];
    logic [`CACHE_BLOCK_SIZE - 1:0] line_data [LINES];

    cache_state_t                  state;
    cache_state_t                  next_state;
    logic [COUNT_BITS - 1:0]       counter; // beat within the current burst

    logic                          tag_match;
    logic                          store_hit;
    logic                          last_beat;

    assign offset = address[OFFSET_BITS - 1:0];
    assign index  = address[INDEX_BITS + OFFSET_BITS - 1:OFFSET_BITS];
    assign tag    = address[15:INDEX_BITS + OFFSET_BITS];

    assign tag_match = line_valid[index] && (line_tag[index] == tag);
    assign store_hit = hit && (mem_op == STORE);
    assign last_beat = (counter == COUNT_BITS'(BEATS - 1));

    assign rd_word = line_data[index][offset * WORD_BITS +: WORD_BITS];
    assign wr_data = line_data[index][counter * `MEM_TRANS_SIZE +: `MEM_TRANS_SIZE];

    // victim block address for a write-back, requested block otherwise
    assign mem_addr = (state == REQUEST_WRITE) ? {line_tag[index], index} : {tag, index};

    always_comb begin
        hit        = 1'b0;
        miss       = 1'b0;
        mem_req    = NONE;
        next_state = state;
        case (state)
            READY: begin
                hit  = valid && tag_match;
                miss = valid && !tag_match;
                if (miss) begin
                    if (line_valid[index] && line_dirty[index]) begin
                        next_state = REQUEST_WRITE;
                    end else begin
                        next_state = REQUEST_READ;
                    end
                end
            end
            REQUEST_WRITE: begin
                miss    = valid;
                mem_req = WRITE;
                if (mem_ack) begin
                    next_state = WRITING;
                end
            end
            WRITING: begin
                miss = valid;
                if (last_beat) begin
                    next_state = REQUEST_READ; // refill follows straight away
                end
            end
            REQUEST_READ: begin
                miss    = valid;
                mem_req = READ;
                if (mem_ack) begin
                    next_state = READING;
                end
            end
            READING: begin
                miss = valid;
                if (last_beat) begin
                    next_state = READY; // held access hits next cycle
                end
            end
            default: begin
                next_state = READY;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state      <= READY;
            counter    <= '0;
            line_valid <= '0;
            line_dirty <= '0;
        end else begin
            state <= next_state;
            case (state)
                READY: begin
                    if (store_hit) begin
                        line_dirty[index] <= 1'b1;
                    end
                end
                REQUEST_WRITE, REQUEST_READ: begin
                    counter <= '0;
                end
                WRITING: begin
                    counter <= counter + 1'b1;
                end
                READING: begin
                    counter <= counter + 1'b1;
                    if (last_beat) begin
                        line_valid[index] <= 1'b1;
                        line_dirty[index] <= 1'b0;
                    end
                end
                default: begin
                    counter <= '0;
                end
            endcase
        end
    end

    // tag and data storage
    always_ff @(posedge clk) begin
        if (store_hit) begin
            line_data[index][offset * WORD_BITS +: WORD_BITS] <= wr_word;
        end
        if (state == READING) begin
            line_data[index][counter * `MEM_TRANS_SIZE +: `MEM_TRANS_SIZE] <= rd_data;
            if (last_beat) begin
                line_tag[index] <= tag;
            end
        end
    end

endmodule

//--- design/d_cache_sys.sv
`timescale 1ns/1ps
`include "nand_cpu_config.svh"

module d_cache_sys
    import nand_cpu_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int INDEX_BITS = 4
) (
    input  logic        clk,
    input  logic        n_rst,

    input  logic        valid,
    input  logic [15:0] address,
    input  mem_op_t     mem_op,
    input  logic [15:0] wr_word,
    output logic        hit,
    output logic        miss,
    output logic [15:0] rd_word
);

    cache_request_t                                mem_req;
    logic [15 - $clog2(`CACHE_BLOCK_SIZE / 16):0]  mem_addr;
    logic [`MEM_TRANS_SIZE - 1:0]                  wr_data;
    logic                                          mem_ack;
    logic [`MEM_TRANS_SIZE - 1:0]                  rd_data;

    d_cache #(
        .INDEX_BITS (INDEX_BITS)
    ) u_d_cache (
        .clk      (clk),
        .n_rst    (n_rst),
        .valid    (valid),
        .address  (address),
        .mem_op   (mem_op),
        .wr_word  (wr_word),
        .hit      (hit),
        .miss     (miss),
        .rd_word  (rd_word),
        .mem_req  (mem_req),
        .mem_addr (mem_addr),
        .wr_data  (wr_data),
        .mem_ack  (mem_ack),
        .rd_data  (rd_data)
    );

    mem_ctrl u_mem_ctrl (
        .clk      (clk),
        .n_rst    (n_rst),
        .mem_req  (mem_req),
        .mem_addr (mem_addr),
        .wr_data  (wr_data),
        .mem_ack  (mem_ack),
        .rd_data  (rd_data)
    );

endmodule

//--- design/mem_bus_pkg.sv
package mem_bus_pkg;

    // burst request level on the memory bus
    typedef enum logic [1:0] {
        NONE,
        READ,
        WRITE
    } cache_request_t;

    // miss handling controller of the data cache
    typedef enum logic [2:0] {
        READY,
        REQUEST_WRITE, // write-back of a dirty victim
        WRITING,
        REQUEST_READ,  // refill of the requested line
        READING
    } cache_state_t;

endpackage

//--- design/mem_ctrl.sv
`timescale 1ns/1ps
`include "nand_cpu_config.svh"

module mem_ctrl
    import mem_bus_pkg::*;
(
    input  logic                                          clk,
    input  logic                                          n_rst,

    input  cache_request_t                                mem_req,
    input  logic [15 - $clog2(`CACHE_BLOCK_SIZE / 16):0]  mem_addr,
    input  logic [`MEM_TRANS_SIZE - 1:0]                  wr_data,
    output logic                                          mem_ack,
    output logic [`MEM_TRANS_SIZE - 1:0]                  rd_data
);

    localparam int BEATS     = `CACHE_BLOCK_SIZE / `MEM_TRANS_SIZE;
    localparam int BEAT_BITS = (BEATS > 1) ? $clog2(BEATS) : 1;
    localparam int LAT_BITS  = $clog2(`MEM_LATENCY + 1);
    localparam int DEPTH     = 2 ** `MEM_DEPTH_BITS;

    typedef enum logic [1:0] {
        MC_IDLE,
        MC_WAIT, // latency count
        MC_ACK,
        MC_XFER  // one beat per cycle
    } mc_state_t;

    mc_state_t                     state;
    logic [LAT_BITS - 1:0]         lat_cnt;
    logic [BEAT_BITS - 1:0]        beat;

    logic [`MEM_DEPTH_BITS - 1:0]  blk; // block latched at request
    logic                          is_write;

    logic [`CACHE_BLOCK_SIZE - 1:0] mem [DEPTH];

    assign mem_ack = (state == MC_ACK);
    assign rd_data = mem[blk][beat * `MEM_TRANS_SIZE +: `MEM_TRANS_SIZE];

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state   <= MC_IDLE;
            lat_cnt <= '0;
            beat    <= '0;
        end else begin
            case (state)
                MC_IDLE: begin
                    if (mem_req != NONE) begin
                        lat_cnt <= LAT_BITS'(1);
                        if (`MEM_LATENCY > 1) begin
                            state <= MC_WAIT;
                        end else begin
                            state <= MC_ACK;
                        end
                    end
                end
                MC_WAIT: begin
                    if (lat_cnt == LAT_BITS'(`MEM_LATENCY - 1)) begin
                        state <= MC_ACK;
                    end else begin
                        lat_cnt <= lat_cnt + 1'b1;
                    end
                end
                MC_ACK: begin
                    beat  <= '0;
                    state <= MC_XFER;
                end
                MC_XFER: begin
                    beat <= beat + 1'b1;
                    if (beat == BEAT_BITS'(BEATS - 1)) begin
                        state <= MC_IDLE;
                    end
                end
                default: begin
                    state <= MC_IDLE;
                end
            endcase
        end
    end

    // request capture and array writes
    always_ff @(posedge clk) begin
        if (state == MC_IDLE && mem_req != NONE) begin
            blk      <= mem_addr[`MEM_DEPTH_BITS - 1:0];
            is_write <= (mem_req == WRITE);
        end
        if (state == MC_XFER && is_write) begin
            mem[blk][beat * `MEM_TRANS_SIZE +: `MEM_TRANS_SIZE] <= wr_data;
        end
    end

endmodule

//--- design/nand_cpu_config.svh
`ifndef NAND_CPU_CONFIG_SVH
`define NAND_CPU_CONFIG_SVH

// geometry of one cache line and one memory bus beat
`define CACHE_BLOCK_SIZE 64 // bits per line, four 16-bit words
`define MEM_TRANS_SIZE   16 // bits per beat

// backing store
`define MEM_DEPTH_BITS   8  // low block-address bits decoded by the array
`define MEM_LATENCY      3  // cycles from request seen to ack

// a block is streamed as CACHE_BLOCK_SIZE / MEM_TRANS_SIZE beats,
// the first one in the cycle after the ack

`endif

//--- design/nand_cpu_pkg.sv
package nand_cpu_pkg;

    // kind of access presented by the CPU
    typedef enum logic {
        LOAD,
        STORE
    } mem_op_t;

endpackage

//--- run.sh
#!/bin/sh
# build and run the d_cache testbench with Verilator

verilator --binary --assert --timing -Wno-fatal -f src.f --top-module d_cache_tb -o d_cache_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/d_cache_tb +verilator+error+limit+100)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi

echo "simulation did not report a pass"
exit 1

//--- src.f
+incdir+design
design/nand_cpu_pkg.sv
design/mem_bus_pkg.sv
design/d_cache.sv
design/mem_ctrl.sv
design/d_cache_sys.sv
tb/d_cache_chk.sv
tb/d_cache_tb.sv

//--- tb/d_cache_chk.sv
`timescale 1ns/1ps
`include "nand_cpu_config.svh"

module d_cache_chk
    import mem_bus_pkg::*;
(
    input logic                                         clk,
    input logic                                         n_rst,
    input logic                                         valid,
    input logic                                         hit,
    input logic                                         miss,
    input cache_request_t                               mem_req,
    input logic [15 - $clog2(`CACHE_BLOCK_SIZE / 16):0] mem_addr,
    input logic                                         mem_ack,
    input cache_state_t                                 state
);

    logic protocol_fail = 1'b0; // watched by the testbench

    // bus idle and controller ready once reset is released
    reset_idle: assert property (@(posedge clk)
        $rose(n_rst) |-> (mem_req == NONE) && !mem_ack && (state == READY))
    else begin
        $error("bus not idle or cache not ready after reset");
        protocol_fail = 1'b1;
    end

    no_access: assert property (@(posedge clk) disable iff (!n_rst)
        !valid |-> !hit && !miss)
    else begin
        $error("hit or miss raised without an access");
        protocol_fail = 1'b1;
    end

    hit_xor_miss: assert property (@(posedge clk) disable iff (!n_rst)
        !(hit && miss))
    else begin
        $error("hit and miss high together");
        protocol_fail = 1'b1;
    end

    // the held access sees miss for the whole burst sequence
    miss_held: assert property (@(posedge clk) disable iff (!n_rst)
        (state != READY) |-> miss)
    else begin
        $error("miss dropped while a line was being replaced");
        protocol_fail = 1'b1;
    end

    req_hold: assert property (@(posedge clk) disable iff (!n_rst)
        (mem_req != NONE) && !mem_ack |=> $stable(mem_req) && $stable(mem_addr))
    else begin
        $error("request or block address changed before the ack");
        protocol_fail = 1'b1;
    end

    ack_with_req: assert property (@(posedge clk) disable iff (!n_rst)
        mem_ack |-> (mem_req != NONE))
    else begin
        $error("ack without a pending request");
        protocol_fail = 1'b1;
    end

    // four beats follow each ack, then the burst state is left
    last_beat: assert property (@(posedge clk) disable iff (!n_rst)
        $past(mem_ack, 4) |-> (state == WRITING) || (state == READING))
    else begin
        $error("burst ended before its fourth beat");
        protocol_fail = 1'b1;
    end

    burst_end: assert property (@(posedge clk) disable iff (!n_rst)
        $past(mem_ack, 5) |-> (state == READY) || (state == REQUEST_READ))
    else begin
        $error("burst ran past its fourth beat");
        protocol_fail = 1'b1;
    end

endmodule

bind d_cache_sys d_cache_chk chk (
    .clk      (clk),
    .n_rst    (n_rst),
    .valid    (valid),
    .hit      (hit),
    .miss     (miss),
    .mem_req  (mem_req),
    .mem_addr (mem_addr),
    .mem_ack  (mem_ack),
    .state    (u_d_cache.state)
);

//--- tb/d_cache_tb.sv
`timescale 1ns/1ps
`include "nand_cpu_config.svh"

module d_cache_tb
    import nand_cpu_pkg::*;
();

    localparam int CLK_PERIOD        = 20;
    localparam int RESET_CYCLES      = 16;
    localparam int BEATS             = `CACHE_BLOCK_SIZE / `MEM_TRANS_SIZE;
    localparam int DIRECTED_ACCESSES = 6;
    localparam int RANDOM_ACCESSES   = 200;
    localparam int WINDOW_WORDS      = 256; // four tags per index with 16 lines
    localparam logic [15:0] WINDOW_BASE = 16'h0000;

    // dirty miss is two bursts plus the miss cycle, the hit cycle and a spare
    localparam int WORST_ACCESS    = 2 * (`MEM_LATENCY + 1 + BEATS) + 3;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 20
                                     + (DIRECTED_ACCESSES + RANDOM_ACCESSES) * WORST_ACCESS;

    logic        clk;
    logic        n_rst;
    logic        valid;
    logic [15:0] address;
    mem_op_t     mem_op;
    logic [15:0] wr_word;
    logic        hit;
    logic        miss;
    logic [15:0] rd_word;

    logic [15:0] shadow [logic [15:0]]; // words written so far

    d_cache_sys dut (
        .clk     (clk),
        .n_rst   (n_rst),
        .valid   (valid),
        .address (address),
        .mem_op  (mem_op),
        .wr_word (wr_word),
        .hit     (hit),
        .miss    (miss),
        .rd_word (rd_word)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the edge that ends the hit cycle
    task automatic run_access(input logic [15:0] addr, input mem_op_t op,
                              input logic [15:0] data, input bit must_hit);
        int          waited;
        logic [15:0] expected;
        waited   = 0;
        expected = (op == LOAD) ? shadow[addr] : data;
        valid    = 1'b1;
        address  = addr;
        mem_op   = op;
        wr_word  = data;
        @(negedge clk);
        while (!hit) begin
            waited++;
            @(negedge clk);
        end
        if (op == LOAD) begin
            assert (rd_word == expected) else begin
                $display("Error: rd_word expected %h actual %h at address %h",
                         expected, rd_word, addr);
                abort_run("load returned a wrong word");
            end
        end
        assert (!must_hit || waited == 0) else begin
            abort_run("an access to a resident line took a miss");
        end
        if (op == STORE) begin
            shadow[addr] = data;
        end
        @(posedge clk);
        #1;
        valid = 1'b0;
    endtask

    // ends the run if the tests take longer than the worst case allows
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("timeout, the accesses did not all complete in time");
    end

    initial begin
        wait (dut.chk.protocol_fail);
        abort_run("a bus protocol assertion failed");
    end

    initial begin
        logic [15:0] addr;
        logic [15:0] data;
        mem_op_t     op;

        void'($urandom(72));
        n_rst   = 1'b0;
        valid   = 1'b0;
        address = '0;
        mem_op  = LOAD;
        wr_word = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        n_rst = 1'b1;
        repeat (3) @(posedge clk); // idle bus after reset
        #1;

        // cold store then a resident load
        run_access(16'h0012, STORE, 16'h1234, 1'b0);
        run_access(16'h0012, LOAD, 16'h0000, 1'b1);

        // same index, other tag, so the dirty line goes back to memory
        run_access(16'h0052, STORE, 16'hbeef, 1'b0);
        run_access(16'h0012, LOAD, 16'h0000, 1'b0);
        run_access(16'h0052, LOAD, 16'h0000, 1'b0);
        run_access(16'h0012, LOAD, 16'h0000, 1'b0);

        for (int i = 0; i < RANDOM_ACCESSES; i++) begin
            addr = WINDOW_BASE + 16'($urandom % WINDOW_WORDS);
            op   = ($urandom % 2 == 0) ? LOAD : STORE;
            data = 16'($urandom);
            if (!shadow.exists(addr)) begin
                op = STORE; // never load a word that memory holds as garbage
            end
            run_access(addr, op, data, 1'b0);
        end

        repeat (4) @(posedge clk);
        if (dut.chk.protocol_fail) begin
            abort_run("a bus protocol assertion failed");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule
